// File: verilog/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

  // data and instruction word
  typedef logic [31:0] word_t;
  // register index, r15 is not stored
  typedef logic [3:0] reg_idx_t;

  // memory depths in words
  localparam int CODE_WORDS = 16;
  localparam int DATA_WORDS = 8;

  // destination index meaning no register write
  localparam reg_idx_t R_NONE = 4'd15;

  // instruction class, bits 27:26
  typedef enum logic [1:0] {
    type_data_proc = 2'b00,
    type_ldr_str   = 2'b01,
    type_branch    = 2'b10
  } inst_type_e;

  // data processing opcodes that the core executes
  typedef enum logic [3:0] {
    op_and = 4'b0000,
    op_eor = 4'b0001,
    op_sub = 4'b0010,
    op_add = 4'b0100,
    op_cmp = 4'b1010,
    op_orr = 4'b1100,
    op_mov = 4'b1101,
    op_bic = 4'b1110,
    op_mvn = 4'b1111
  } opcode_e;

  // condition codes, 4'b1111 never passes
  typedef enum logic [3:0] {
    cond_eq, cond_ne, cond_cs, cond_cc, cond_mi, cond_pl, cond_vs, cond_vc,
    cond_hi, cond_ls, cond_ge, cond_lt, cond_gt, cond_le, cond_al
  } cond_e;

  // status flags in cpsr order
  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } flags_t;

  // field positions (lsb of each field)
  localparam int COND_LSB  = 28;
  localparam int TYPE_LSB  = 26;
  localparam int IMM_BIT   = 25;
  localparam int OPC_LSB   = 21;
  localparam int S_BIT     = 20;
  localparam int LOAD_BIT  = 20;
  localparam int RN_LSB    = 16;
  localparam int RD_LSB    = 12;
  localparam int RM_LSB    = 0;
  localparam int IMM8_LSB  = 0;
  localparam int IMM12_LSB = 0;
  localparam int IMM24_LSB = 0;

endpackage

`default_nettype wire

// File: verilog/fetch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module fetch_stage #(
  parameter int code_words = cpu_pkg::CODE_WORDS
) (
  input  wire                            clk,
  input  wire                            nreset,
  input  wire                            run,
  input  wire                            stall,
  input  wire                            redirect,
  input  wire cpu_pkg::word_t            redirect_pc,
  input  wire                            prog_valid,
  input  wire [$clog2(code_words)-1:0]   prog_addr,
  input  wire cpu_pkg::word_t            prog_data,
  output logic                           prog_ready,
  output cpu_pkg::word_t                 pc,
  output logic                           fd_valid,
  output cpu_pkg::word_t                 fd_inst,
  output cpu_pkg::word_t                 fd_pc
);
  import cpu_pkg::*;

  localparam int aw = $clog2(code_words);
  localparam int code_bytes = code_words * 4;

  word_t code_mem [0:code_words-1];
  word_t pc_inc;
  logic [aw-1:0] code_addr;

  // loading is only allowed while the core is stopped
  assign prog_ready = !run;

  always_ff @(posedge clk) begin
    if (prog_valid && prog_ready) begin
      code_mem[prog_addr] <= prog_data;
    end
  end

  assign code_addr = pc[aw+1:2];
  assign pc_inc = pc + 32'd4;

  // pc: redirect wins over stall, wraps at the end of code memory
  always_ff @(posedge clk) begin
    if (!nreset || !run) begin
      pc <= '0;
    end else if (redirect) begin
      pc <= redirect_pc;
    end else if (!stall) begin
      pc <= (pc_inc >= code_bytes) ? '0 : pc_inc;
    end
  end

  // fetch/decode valid, flushed by a taken branch
  always_ff @(posedge clk) begin
    if (!nreset || !run || redirect) begin
      fd_valid <= 1'b0;
    end else if (!stall) begin
      fd_valid <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      fd_inst <= code_mem[code_addr];
      fd_pc   <= pc;
    end
  end

endmodule

`default_nettype wire

// File: verilog/decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module decode_stage (
  input  wire                         clk,
  input  wire                         nreset,
  input  wire                         run,
  input  wire                         fd_valid,
  input  wire cpu_pkg::word_t         fd_inst,
  input  wire cpu_pkg::word_t         fd_pc,
  input  wire                         redirect,
  input  wire                         wb_valid,
  input  wire                         wb_we,
  input  wire cpu_pkg::reg_idx_t      wb_rd,
  input  wire cpu_pkg::word_t         wb_data,
  input  wire cpu_pkg::reg_idx_t      dbg_sel,
  output logic                        stall,
  output cpu_pkg::word_t              dbg_data,
  output logic                        de_valid,
  output cpu_pkg::inst_type_e         de_type,
  output cpu_pkg::opcode_e            de_opcode,
  output cpu_pkg::cond_e              de_cond,
  output logic                        de_set_flags,
  output logic                        de_use_imm,
  output cpu_pkg::word_t              de_imm,
  output logic                        de_is_load,
  output logic                        de_is_store,
  output cpu_pkg::reg_idx_t           de_rn,
  output cpu_pkg::reg_idx_t           de_rm,
  output cpu_pkg::reg_idx_t           de_rd,
  output cpu_pkg::word_t              rn_val,
  output cpu_pkg::word_t              rm_val,
  output cpu_pkg::word_t              rd_val,
  output cpu_pkg::word_t              de_pc
);
  import cpu_pkg::*;

  // r0..r14, r15 has no storage
  word_t rf [0:14];

  inst_type_e f_type;
  opcode_e    f_opcode;
  reg_idx_t   f_rn;
  reg_idx_t   f_rd;
  reg_idx_t   f_rm;
  word_t      f_imm;
  logic       f_dp;
  logic       f_ls;
  logic       f_load;
  logic       f_store;
  logic       f_writes;
  logic       uses_rn;
  logic       uses_rm;
  logic       uses_rd;

  // read with write-through from the write-back port
  function automatic word_t rf_read(reg_idx_t idx);
    if (idx == R_NONE) begin
      return '0;
    end
    if (wb_valid && wb_we && wb_rd == idx) begin
      return wb_data;
    end
    return rf[idx];
  endfunction

  //////////////////////////////////////////////////////////////////////
  // field split
  assign f_type   = inst_type_e'(fd_inst[TYPE_LSB +: 2]);
  assign f_opcode = opcode_e'(fd_inst[OPC_LSB +: 4]);
  assign f_rn     = fd_inst[RN_LSB +: 4];
  assign f_rd     = fd_inst[RD_LSB +: 4];
  assign f_rm     = fd_inst[RM_LSB +: 4];

  assign f_dp    = (f_type == type_data_proc);
  assign f_ls    = (f_type == type_ldr_str);
  assign f_load  = f_ls && fd_inst[LOAD_BIT];
  assign f_store = f_ls && !fd_inst[LOAD_BIT];
  // cmp only sets flags
  assign f_writes = (f_dp && f_opcode != op_cmp) || f_load;

  // imm8 and imm12 zero extend, branch offset in bytes
  always_comb begin
    case (f_type)
      type_data_proc: f_imm = {24'd0, fd_inst[IMM8_LSB +: 8]};
      type_ldr_str:   f_imm = {20'd0, fd_inst[IMM12_LSB +: 12]};
      default:        f_imm = {{6{fd_inst[IMM24_LSB+23]}}, fd_inst[IMM24_LSB +: 24], 2'b00};
    endcase
  end

  // which register reads matter for the interlock
  assign uses_rn = (f_dp && f_opcode != op_mov && f_opcode != op_mvn) || f_ls;
  assign uses_rm = f_dp && !fd_inst[IMM_BIT];
  assign uses_rd = f_store;

  // load in execute feeding this instruction, one bubble
  assign stall = run && fd_valid && de_valid && de_is_load && de_rd != R_NONE &&
                 ((uses_rn && f_rn == de_rd) ||
                  (uses_rm && f_rm == de_rd) ||
                  (uses_rd && f_rd == de_rd));

  //////////////////////////////////////////////////////////////////////
  // register file
  always_ff @(posedge clk) begin
    if (!nreset) begin
      for (int i = 0; i < 15; i++) begin
        rf[i] <= '0;
      end
    end else if (wb_valid && wb_we && wb_rd != R_NONE) begin
      rf[wb_rd] <= wb_data;
    end
  end

  assign dbg_data = (dbg_sel == R_NONE) ? '0 : rf[dbg_sel];

  //////////////////////////////////////////////////////////////////////
  // decode/execute register
  always_ff @(posedge clk) begin
    if (!nreset) begin
      de_valid <= 1'b0;
    end else begin
      de_valid <= run && fd_valid && !redirect && !stall;
    end
  end

  always_ff @(posedge clk) begin
    de_type      <= f_type;
    de_opcode    <= f_opcode;
    de_cond      <= cond_e'(fd_inst[COND_LSB +: 4]);
    de_set_flags <= f_dp && fd_inst[S_BIT];
    // loads and stores always take the imm12 offset
    de_use_imm   <= (f_dp && fd_inst[IMM_BIT]) || f_ls;
    de_imm       <= f_imm;
    de_is_load   <= f_load;
    de_is_store  <= f_store;
    de_rn        <= f_rn;
    de_rm        <= f_rm;
    // store keeps rd as its data source
    de_rd        <= (f_writes || f_store) ? f_rd : R_NONE;
    rn_val       <= rf_read(f_rn);
    rm_val       <= rf_read(f_rm);
    rd_val       <= rf_read(f_rd);
    de_pc        <= fd_pc;
  end

endmodule

`default_nettype wire

// File: verilog/execute_stage.sv
`timescale 1ns/10ps
`default_nettype none

module execute_stage #(
  parameter int data_words = cpu_pkg::DATA_WORDS
) (
  input  wire                                clk,
  input  wire                                nreset,
  input  wire                                run,
  input  wire                                de_valid,
  input  wire cpu_pkg::inst_type_e           de_type,
  input  wire cpu_pkg::opcode_e              de_opcode,
  input  wire cpu_pkg::cond_e                de_cond,
  input  wire                                de_set_flags,
  input  wire                                de_use_imm,
  input  wire cpu_pkg::word_t                de_imm,
  input  wire                                de_is_load,
  input  wire                                de_is_store,
  input  wire cpu_pkg::reg_idx_t             de_rn,
  input  wire cpu_pkg::reg_idx_t             de_rm,
  input  wire cpu_pkg::reg_idx_t             de_rd,
  input  wire cpu_pkg::word_t                rn_val,
  input  wire cpu_pkg::word_t                rm_val,
  input  wire cpu_pkg::word_t                rd_val,
  input  wire cpu_pkg::word_t                de_pc,
  input  wire                                wb_valid,
  input  wire                                wb_we,
  input  wire cpu_pkg::reg_idx_t             wb_rd,
  input  wire cpu_pkg::word_t                wb_data,
  output logic                               redirect,
  output cpu_pkg::word_t                     redirect_pc,
  output logic                               em_valid,
  output logic                               em_we_rf,
  output cpu_pkg::reg_idx_t                  em_rd,
  output cpu_pkg::word_t                     em_result,
  output logic                               em_is_load,
  output logic                               em_is_store,
  output logic [$clog2(data_words)-1:0]      em_addr,
  output cpu_pkg::word_t                     em_store_data
);
  import cpu_pkg::*;

  localparam int daw = $clog2(data_words);

  flags_t      flags;
  word_t       op_a;
  word_t       op_b;
  word_t       op_d;
  opcode_e     alu_op;
  logic [32:0] sum;
  word_t       res;
  logic        carry;
  logic        ovf;
  logic        flag_we;

  // memory stage first, loads there are not ready yet
  function automatic word_t fwd(reg_idx_t idx, word_t rf_val);
    if (em_valid && em_we_rf && !em_is_load && em_rd == idx) begin
      return em_result;
    end
    if (wb_valid && wb_we && wb_rd == idx) begin
      return wb_data;
    end
    return rf_val;
  endfunction

  function automatic logic cond_pass(cond_e c, flags_t f);
    case (c)
      cond_eq: return f.z;
      cond_ne: return !f.z;
      cond_cs: return f.c;
      cond_cc: return !f.c;
      cond_mi: return f.n;
      cond_pl: return !f.n;
      cond_vs: return f.v;
      cond_vc: return !f.v;
      cond_hi: return f.c && !f.z;
      cond_ls: return !f.c || f.z;
      cond_ge: return f.n == f.v;
      cond_lt: return f.n != f.v;
      cond_gt: return !f.z && (f.n == f.v);
      cond_le: return f.z || (f.n != f.v);
      cond_al: return 1'b1;
      default: return 1'b0;
    endcase
  endfunction

  //////////////////////////////////////////////////////////////////////
  // operands and alu
  assign op_a = fwd(de_rn, rn_val);
  assign op_b = de_use_imm ? de_imm : fwd(de_rm, rm_val);
  // store data
  assign op_d = fwd(de_rd, rd_val);

  // the adder also forms load/store addresses
  assign alu_op = (de_type == type_ldr_str) ? op_add : de_opcode;

  always_comb begin
    sum   = '0;
    carry = flags.c;
    ovf   = flags.v;
    case (alu_op)
      op_and: res = op_a & op_b;
      op_eor: res = op_a ^ op_b;
      op_sub, op_cmp: begin
        // carry set means no borrow
        sum   = {1'b0, op_a} + {1'b0, ~op_b} + 33'd1;
        res   = sum[31:0];
        carry = sum[32];
        ovf   = (op_a[31] != op_b[31]) && (res[31] != op_a[31]);
      end
      op_add: begin
        sum   = {1'b0, op_a} + {1'b0, op_b};
        res   = sum[31:0];
        carry = sum[32];
        ovf   = (op_a[31] == op_b[31]) && (res[31] != op_a[31]);
      end
      op_orr: res = op_a | op_b;
      op_mov: res = op_b;
      op_bic: res = op_a & ~op_b;
      op_mvn: res = ~op_b;
      default: res = op_b;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // flags and branch
  assign flag_we = run && de_valid && de_type == type_data_proc &&
                   (de_set_flags || de_opcode == op_cmp);

  always_ff @(posedge clk) begin
    if (!nreset) begin
      flags <= '0;
    end else if (flag_we) begin
      flags <= '{n: res[31], z: (res == '0), c: carry, v: ovf};
    end
  end

  // target is branch address + 8 + offset
  assign redirect = run && de_valid && de_type == type_branch && cond_pass(de_cond, flags);
  assign redirect_pc = de_pc + 32'd8 + de_imm;

  //////////////////////////////////////////////////////////////////////
  // execute/memory register
  always_ff @(posedge clk) begin
    if (!nreset) begin
      em_valid <= 1'b0;
      em_we_rf <= 1'b0;
    end else begin
      em_valid <= run && de_valid;
      em_we_rf <= run && de_valid && !de_is_store && de_rd != R_NONE;
    end
  end

  always_ff @(posedge clk) begin
    em_rd         <= de_rd;
    em_result     <= res;
    em_is_load    <= de_is_load;
    em_is_store   <= de_is_store;
    // byte address to word index
    em_addr       <= res[daw+1:2];
    em_store_data <= op_d;
  end

endmodule

`default_nettype wire

// File: verilog/mem_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mem_stage #(
  parameter int data_words = cpu_pkg::DATA_WORDS
) (
  input  wire                                clk,
  input  wire                                nreset,
  input  wire                                em_valid,
  input  wire                                em_we_rf,
  input  wire cpu_pkg::reg_idx_t             em_rd,
  input  wire cpu_pkg::word_t                em_result,
  input  wire                                em_is_load,
  input  wire                                em_is_store,
  input  wire [$clog2(data_words)-1:0]       em_addr,
  input  wire cpu_pkg::word_t                em_store_data,
  output logic                               wb_valid,
  output logic                               wb_we,
  output cpu_pkg::reg_idx_t                  wb_rd,
  output cpu_pkg::word_t                     wb_data
);
  import cpu_pkg::*;

  word_t data_mem [0:data_words-1];

  // store writes at the edge, a following load reads it next cycle
  always_ff @(posedge clk) begin
    if (em_valid && em_is_store) begin
      data_mem[em_addr] <= em_store_data;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory/write-back register
  always_ff @(posedge clk) begin
    if (!nreset) begin
      wb_valid <= 1'b0;
      wb_we    <= 1'b0;
    end else begin
      wb_valid <= em_valid;
      wb_we    <= em_we_rf;
    end
  end

  // load data replaces the alu result
  always_ff @(posedge clk) begin
    wb_rd   <= em_rd;
    wb_data <= em_is_load ? data_mem[em_addr] : em_result;
  end

endmodule

`default_nettype wire

// File: verilog/cpu_top.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_top #(
  parameter int code_words = cpu_pkg::CODE_WORDS,
  parameter int data_words = cpu_pkg::DATA_WORDS
) (
  input  wire                            clk,
  input  wire                            nreset,
  input  wire                            run,
  // code memory load port
  input  wire                            prog_valid,
  input  wire [$clog2(code_words)-1:0]   prog_addr,
  input  wire cpu_pkg::word_t            prog_data,
  output logic                           prog_ready,
  // register peek
  input  wire cpu_pkg::reg_idx_t         dbg_sel,
  output cpu_pkg::word_t                 dbg_data,
  // status
  output cpu_pkg::word_t                 pc,
  output logic                           led
);
  import cpu_pkg::*;

  localparam int daw = $clog2(data_words);

  // led blinks with the low order word bit of the fetch address
  assign led = pc[2];

  //////////////////////////////////////////////////////////////////////
  // pipeline control
  logic       stall;
  logic       redirect;
  word_t      redirect_pc;

  // fetch to decode
  logic       fd_valid;
  word_t      fd_inst;
  word_t      fd_pc;

  // decode to execute
  logic       de_valid;
  inst_type_e de_type;
  opcode_e    de_opcode;
  cond_e      de_cond;
  logic       de_set_flags;
  logic       de_use_imm;
  word_t      de_imm;
  logic       de_is_load;
  logic       de_is_store;
  reg_idx_t   de_rn;
  reg_idx_t   de_rm;
  reg_idx_t   de_rd;
  word_t      rn_val;
  word_t      rm_val;
  word_t      rd_val;
  word_t      de_pc;

  // execute to memory, also the first forwarding source
  logic           em_valid;
  logic           em_we_rf;
  reg_idx_t       em_rd;
  word_t          em_result;
  logic           em_is_load;
  logic           em_is_store;
  logic [daw-1:0] em_addr;
  word_t          em_store_data;

  // write-back port, also the second forwarding source
  logic       wb_valid;
  logic       wb_we;
  reg_idx_t   wb_rd;
  word_t      wb_data;

  //////////////////////////////////////////////////////////////////////
  // stages
  fetch_stage #(.code_words(code_words)) i_fetch (.*);

  decode_stage i_decode (.*);

  execute_stage #(.data_words(data_words)) i_execute (.*);

  mem_stage #(.data_words(data_words)) i_mem (.*);

endmodule

`default_nettype wire

// File: dv/cpu_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module cpu_assertions (
  input wire                 clk,
  input wire                 nreset,
  input wire                 stall,
  input wire cpu_pkg::word_t pc
);

  // the interlock freezes fetch while it inserts its bubble
  pc_held_on_stall: assert property (
    @(posedge clk) disable iff (!nreset) stall |=> $stable(pc)
  ) else $error("pc moved during a load-use stall");

  // the load-use interlock inserts a single bubble
  stall_one_cycle: assert property (
    @(posedge clk) disable iff (!nreset) stall |=> !stall
  ) else $error("stall held for two consecutive cycles");

  // reset returns fetch to address 0
  pc_zero_after_reset: assert property (
    @(posedge clk) !nreset |=> (pc == '0)
  ) else $error("pc is not 0 in the cycle after reset");

endmodule

bind cpu_top cpu_assertions i_assertions (
  .clk(clk),
  .nreset(nreset),
  .stall(stall),
  .pc(pc)
);

`default_nettype wire

// File: dv/tb_cpu.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpu;
  import cpu_pkg::*;

  localparam int code_words = CODE_WORDS;
  localparam int data_words = DATA_WORDS;
  localparam int caw = $clog2(code_words);
  // cycles the core runs each program before it parks on the branch-to-self
  localparam int run_cycles = 60;
  // five tests with up to 200 cycles each
  localparam int timeout_cycles = 5 * 200;

  logic           clk;
  logic           nreset;
  logic           run;
  logic           prog_valid;
  logic [caw-1:0] prog_addr;
  word_t          prog_data;
  logic           prog_ready;
  reg_idx_t       dbg_sel;
  word_t          dbg_data;
  word_t          pc;
  logic           led;

  // program under construction
  word_t prog [$];
  int    cycle_count = 0;

  cpu_top #(.code_words(code_words), .data_words(data_words)) i_dut (
    .clk(clk),
    .nreset(nreset),
    .run(run),
    .prog_valid(prog_valid),
    .prog_addr(prog_addr),
    .prog_data(prog_data),
    .prog_ready(prog_ready),
    .dbg_sel(dbg_sel),
    .dbg_data(dbg_data),
    .pc(pc),
    .led(led)
  );

  // 40 ns period
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_cycles) begin
      $display("timeout: the tests did not finish within %0d cycles", timeout_cycles);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation timed out");
    end
  end

  //////////////////////////////////////////////////////////////////////
  // instruction encoders use condition always unless they build a branch

  // data processing with an 8-bit immediate
  function automatic word_t alu_imm(opcode_e op, logic s, reg_idx_t rn, reg_idx_t rd,
                                    logic [7:0] imm);
    return {cond_al, type_data_proc, 1'b1, op, s, rn, rd, 4'h0, imm};
  endfunction

  // data processing with a register second operand
  function automatic word_t alu_reg(opcode_e op, logic s, reg_idx_t rn, reg_idx_t rd,
                                    reg_idx_t rm);
    return {cond_al, type_data_proc, 1'b0, op, s, rn, rd, 8'h00, rm};
  endfunction

  // pre-indexed word access with the offset added
  function automatic word_t load_store(logic load, reg_idx_t rn, reg_idx_t rd,
                                       logic [11:0] offset);
    return {cond_al, type_ldr_str, 1'b0, 4'b1100, load, rn, rd, offset};
  endfunction

  // target = branch address + 8 + 4 * words
  function automatic word_t branch_inst(cond_e cond, int words);
    logic [23:0] off;
    off = 24'(words);
    return {cond, 4'b1010, off};
  endfunction

  //////////////////////////////////////////////////////////////////////
  // drive and check helpers start and end just after a rising edge

  task automatic check(input string test, input string what, input word_t expected,
                       input word_t actual);
    if (expected !== actual) begin
      $display("Error: %s %s expected %h actual %h", test, what, expected, actual);
      $display("TEST RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic apply_reset();
    nreset <= 1'b0;
    repeat (2) @(posedge clk);
    nreset <= 1'b1;
  endtask

  // one code word per accepted handshake
  task automatic load_program();
    for (int i = 0; i < prog.size(); i++) begin
      prog_valid <= 1'b1;
      prog_addr  <= caw'(i);
      prog_data  <= prog[i];
      @(posedge clk);
      while (!prog_ready) begin
        @(posedge clk);
      end
    end
    prog_valid <= 1'b0;
  endtask

  // append the halt loop then load and run the program and stop the core
  task automatic run_program(input string test);
    prog.push_back(branch_inst(cond_al, -2));
    apply_reset();
    load_program();
    run <= 1'b1;
    @(posedge clk);
    // after the first fetch the pc is one word on and the load port is closed
    @(negedge clk);
    check(test, "prog_ready", 32'd0, {31'd0, prog_ready});
    check(test, "pc", 32'd4, pc);
    check(test, "led", 32'd1, {31'd0, led});
    @(posedge clk);
    repeat (run_cycles - 2) @(posedge clk);
    run <= 1'b0;
    @(posedge clk);
  endtask

  // peek port is combinational and is sampled mid cycle
  task automatic read_reg(input reg_idx_t idx, output word_t val);
    dbg_sel <= idx;
    @(negedge clk);
    val = dbg_data;
    @(posedge clk);
  endtask

  task automatic check_reg(input string test, input reg_idx_t idx, input word_t expected);
    word_t val;
    read_reg(idx, val);
    check(test, $sformatf("r%0d", idx), expected, val);
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic load_and_reset();
    prog.delete();
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd1, 8'h5a));
    prog.push_back(alu_imm(op_mvn, 1'b0, 4'd0, 4'd14, 8'h00));
    run_program("load_and_reset");
    check_reg("load_and_reset", 4'd1, 32'h0000_005a);
    check_reg("load_and_reset", 4'd14, 32'hffff_ffff);
    // reset clears what the program wrote
    apply_reset();
    @(negedge clk);
    check("load_and_reset", "prog_ready", 32'd1, {31'd0, prog_ready});
    check("load_and_reset", "led", 32'd0, {31'd0, led});
    check("load_and_reset", "pc", 32'd0, pc);
    @(posedge clk);
    // index 15 has no storage and reads 0
    for (int i = 0; i < 16; i++) begin
      check_reg("load_and_reset", 4'(i), 32'd0);
    end
  endtask

  task automatic imm_data_proc();
    word_t a;
    word_t b;
    word_t c;
    word_t d;
    word_t e;
    a = $urandom() & 32'hff;
    b = $urandom() & 32'hff;
    c = $urandom() & 32'hff;
    d = $urandom() & 32'hff;
    e = $urandom() & 32'hff;
    prog.delete();
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd1, a[7:0]));
    prog.push_back(alu_imm(op_mvn, 1'b0, 4'd0, 4'd2, b[7:0]));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd3, c[7:0]));
    prog.push_back(alu_imm(op_bic, 1'b0, 4'd3, 4'd4, d[7:0]));
    prog.push_back(alu_imm(op_eor, 1'b0, 4'd3, 4'd5, e[7:0]));
    prog.push_back(alu_imm(op_orr, 1'b0, 4'd3, 4'd6, d[7:0]));
    prog.push_back(alu_imm(op_and, 1'b0, 4'd3, 4'd7, e[7:0]));
    run_program("imm_data_proc");
    check_reg("imm_data_proc", 4'd1, a);
    check_reg("imm_data_proc", 4'd2, ~b);
    check_reg("imm_data_proc", 4'd3, c);
    check_reg("imm_data_proc", 4'd4, c & ~d);
    check_reg("imm_data_proc", 4'd5, c ^ e);
    check_reg("imm_data_proc", 4'd6, c | d);
    check_reg("imm_data_proc", 4'd7, c & e);
  endtask

  // most sources come from the previous one or two instructions
  task automatic back_to_back();
    word_t ev [1:8];
    ev[1] = $urandom() & 32'hff;
    ev[2] = $urandom() & 32'hff;
    ev[3] = ev[1] + ev[2];
    ev[4] = ev[3] - ev[1];
    ev[5] = ev[4] + ev[3];
    ev[6] = ev[5] - ev[2];
    ev[7] = ev[2] - ev[6];
    ev[8] = ev[7] + 32'd200;
    prog.delete();
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd1, ev[1][7:0]));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd2, ev[2][7:0]));
    prog.push_back(alu_reg(op_add, 1'b0, 4'd1, 4'd3, 4'd2));
    prog.push_back(alu_reg(op_sub, 1'b0, 4'd3, 4'd4, 4'd1));
    prog.push_back(alu_reg(op_add, 1'b0, 4'd4, 4'd5, 4'd3));
    prog.push_back(alu_reg(op_sub, 1'b0, 4'd5, 4'd6, 4'd2));
    prog.push_back(alu_reg(op_sub, 1'b0, 4'd2, 4'd7, 4'd6));
    prog.push_back(alu_imm(op_add, 1'b0, 4'd7, 4'd8, 8'd200));
    run_program("back_to_back");
    for (int i = 1; i <= 8; i++) begin
      check_reg("back_to_back", 4'(i), ev[i]);
    end
  endtask

  // each branch skips one mov when taken
  task automatic cond_branches();
    // equal operands take eq and ge while ne and lt fall through
    prog.delete();
    prog.push_back(alu_imm(op_cmp, 1'b1, 4'd0, 4'd0, 8'd0));
    prog.push_back(branch_inst(cond_eq, 0));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd1, 8'd1));
    prog.push_back(branch_inst(cond_ne, 0));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd2, 8'd2));
    prog.push_back(branch_inst(cond_ge, 0));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd3, 8'd3));
    prog.push_back(branch_inst(cond_lt, 0));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd4, 8'd4));
    run_program("cond_branches eq");
    check_reg("cond_branches eq", 4'd1, 32'd0);
    check_reg("cond_branches eq", 4'd2, 32'd2);
    check_reg("cond_branches eq", 4'd3, 32'd0);
    check_reg("cond_branches eq", 4'd4, 32'd4);
    // 3 - 7 is negative without overflow so lt and ne are taken
    prog.delete();
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd1, 8'd3));
    prog.push_back(alu_imm(op_cmp, 1'b1, 4'd1, 4'd0, 8'd7));
    prog.push_back(branch_inst(cond_lt, 0));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd2, 8'd2));
    prog.push_back(branch_inst(cond_ge, 0));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd3, 8'd3));
    prog.push_back(branch_inst(cond_ne, 0));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd4, 8'd4));
    prog.push_back(branch_inst(cond_eq, 0));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd5, 8'd5));
    run_program("cond_branches lt");
    check_reg("cond_branches lt", 4'd1, 32'd3);
    check_reg("cond_branches lt", 4'd2, 32'd0);
    check_reg("cond_branches lt", 4'd3, 32'd3);
    check_reg("cond_branches lt", 4'd4, 32'd0);
    check_reg("cond_branches lt", 4'd5, 32'd5);
  endtask

  task automatic store_then_load();
    word_t a;
    word_t b;
    a = $urandom() & 32'hff;
    b = $urandom() & 32'hff;
    prog.delete();
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd1, a[7:0]));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd2, 8'd8));
    // word 3 through a base register
    prog.push_back(load_store(1'b0, 4'd2, 4'd1, 12'd4));
    prog.push_back(load_store(1'b1, 4'd2, 4'd3, 12'd4));
    prog.push_back(alu_reg(op_add, 1'b0, 4'd3, 4'd4, 4'd1));
    prog.push_back(alu_imm(op_mov, 1'b0, 4'd0, 4'd5, b[7:0]));
    // word 7 is the last one
    prog.push_back(load_store(1'b0, 4'd0, 4'd5, 12'd28));
    prog.push_back(load_store(1'b1, 4'd0, 4'd6, 12'd28));
    prog.push_back(alu_imm(op_add, 1'b0, 4'd6, 4'd7, 8'd1));
    run_program("store_then_load");
    check_reg("store_then_load", 4'd3, a);
    check_reg("store_then_load", 4'd4, a + a);
    check_reg("store_then_load", 4'd6, b);
    check_reg("store_then_load", 4'd7, b + 32'd1);
  endtask

  //////////////////////////////////////////////////////////////////////
  initial begin
    clk        = 1'b0;
    nreset     = 1'b0;
    run        = 1'b0;
    prog_valid = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    dbg_sel    = '0;
    void'($urandom(32'h29af4c5d));
    @(posedge clk);
    load_and_reset();
    imm_data_proc();
    back_to_back();
    cond_branches();
    store_then_load();
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: src.f
verilog/cpu_pkg.sv
verilog/fetch_stage.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/mem_stage.sv
verilog/cpu_top.sv
dv/cpu_assertions.sv
dv/tb_cpu.sv

// File: run.sh
#!/bin/sh
# compile the cpu testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module tb_cpu -f src.f -o tb_cpu
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

output=$(./obj_dir/tb_cpu)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "^TEST RESULT: PASS$"; then
  exit 0
fi
echo "pass message not found in simulation output"
exit 1
